//--- tile_pkg.sv
`default_nettype none

package tile_pkg;

    // Screen and tile geometry
    localparam int SCREEN_W      = 160;
    localparam int SCREEN_H      = 120;
    localparam int TILE_SIZE     = 20;
    localparam int GRID_W        = 8;
    localparam int GRID_H        = 6;
    localparam int SCREEN_PIXELS = 19200;

    typedef logic [8:0] colour_t;          // RRR_GGG_BBB

    // Never produced by a sprite rule as a visible colour
    localparam colour_t TRANSPARENT_KEY      = 9'b111_000_111;
    localparam colour_t SPRITE_SOLID_COLOUR  = 9'b000_111_000;
    localparam colour_t SPRITE_BORDER_COLOUR = 9'b111_111_000;
    localparam colour_t SPRITE_CHECK_COLOUR  = 9'b000_011_111;
    localparam colour_t SPRITE_DIAG_COLOUR   = 9'b111_010_000;

    typedef logic [14:0] map_addr_t;
    typedef logic [4:0]  tile_pos_t;       // 0 to 19 inside a tile

    typedef struct packed {
        logic [7:0] x;
        logic [6:0] y;
        colour_t    colour;
    } pixel_t;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_ERASE = 2'd1,
        OP_DRAW  = 2'd2,
        OP_CLEAR = 2'd3
    } paint_op_t;

    typedef struct packed {
        logic [3:0] tile_x;
        logic [2:0] tile_y;
        logic [1:0] sprite_id;
    } tile_arg_t;

    // Same 9 bits, read as a tile target or as a fill colour
    typedef union packed {
        tile_arg_t tile;
        colour_t   fill;
    } paint_arg_u;

    typedef struct packed {
        paint_op_t  op;
        paint_arg_u arg;
    } paint_cmd_t;

    // Row-major frame buffer address
    function automatic map_addr_t pixel_address(input logic [7:0] x, input logic [6:0] y);
        return map_addr_t'(y * SCREEN_W + x);
    endfunction

endpackage

`default_nettype wire

//--- sprite_pattern.sv
`timescale 1ns/100ps
`default_nettype none

module sprite_pattern (
    input  logic [1:0]         sprite_id,
    input  tile_pkg::tile_pos_t px,
    input  tile_pkg::tile_pos_t py,
    output tile_pkg::colour_t  colour
);
    import tile_pkg::*;

    localparam tile_pos_t POS_LAST = tile_pos_t'(TILE_SIZE - 1);

    logic on_border;
    logic check_even;
    logic on_diag;

    assign on_border = (px == '0) || (py == '0) || (px == POS_LAST) || (py == POS_LAST);

    // 4x4 cells, so the cell parity sits in bit 2
    assign check_even = (px[2] ^ py[2]) == 1'b0;

    // Main and anti diagonal
    assign on_diag = (px == py) || (({1'b0, px} + {1'b0, py}) == 6'(TILE_SIZE - 1));

    always_comb begin
        colour = TRANSPARENT_KEY;
        case (sprite_id)
            2'd0: colour = SPRITE_SOLID_COLOUR;
            2'd1: begin
                if (on_border) colour = SPRITE_BORDER_COLOUR;   // Hollow frame
            end
            2'd2: begin
                if (check_even) colour = SPRITE_CHECK_COLOUR;
            end
            2'd3: begin
                if (on_diag) colour = SPRITE_DIAG_COLOUR;       // X shape
            end
        endcase
    end

endmodule

`default_nettype wire

//--- square_eraser.sv
`timescale 1ns/100ps
`default_nettype none

module square_eraser #(
    parameter int SETTLE_CYCLES = 8
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  logic [3:0]          tile_x,
    input  logic [2:0]          tile_y,
    input  tile_pkg::colour_t   map_colour,
    output tile_pkg::map_addr_t map_address,
    output logic                plot,
    output tile_pkg::pixel_t    pixel,
    output logic                done
);
    import tile_pkg::*;

    localparam int             CW          = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;
    localparam logic [CW-1:0]  SETTLE_LAST = CW'(SETTLE_CYCLES - 1);
    localparam tile_pos_t      POS_LAST    = tile_pos_t'(TILE_SIZE - 1);

    logic [3:0]    tile_x_q;
    logic [2:0]    tile_y_q;
    logic          settling;
    logic          walking;
    logic [CW-1:0] settle_cnt;
    tile_pos_t     col;
    tile_pos_t     row;
    logic          at_last;
    logic          last_q;
    logic [7:0]    cur_x;
    logic [6:0]    cur_y;
    logic [7:0]    x_q;
    logic [6:0]    y_q;

    assign cur_x       = 8'(tile_x_q * TILE_SIZE) + {3'b000, col};
    assign cur_y       = 7'(tile_y_q * TILE_SIZE) + {2'b00, row};
    assign map_address = pixel_address(cur_x, cur_y);
    assign at_last     = walking && (col == POS_LAST) && (row == POS_LAST);

    // ROM data lands with the delayed position
    assign pixel = '{x: x_q, y: y_q, colour: map_colour};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            settling   <= 1'b0;
            walking    <= 1'b0;
            settle_cnt <= '0;
            col        <= '0;
            row        <= '0;
            plot       <= 1'b0;
            last_q     <= 1'b0;
            done       <= 1'b0;
        end else begin
            plot   <= walking;
            last_q <= at_last;
            done   <= last_q;               // One cycle after the final plot
            if (start) begin
                settling   <= 1'b1;
                walking    <= 1'b0;
                settle_cnt <= '0;
            end else if (settling) begin
                if (settle_cnt == SETTLE_LAST) begin
                    settling <= 1'b0;
                    walking  <= 1'b1;
                    col      <= '0;
                    row      <= '0;
                end else begin
                    settle_cnt <= settle_cnt + 1'b1;
                end
            end else if (walking) begin
                if (col == POS_LAST) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
                if (at_last) walking <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tile_x_q <= tile_x;
            tile_y_q <= tile_y;
        end
        x_q <= cur_x;
        y_q <= cur_y;
    end

    first_plot_after_settle: assert property (@(posedge clk) disable iff (!resetn)
        $rose(plot) |-> $past(start, SETTLE_CYCLES + 2));

endmodule

`default_nettype wire

//--- sprite_drawer.sv
`timescale 1ns/100ps
`default_nettype none

module sprite_drawer (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic [3:0]       tile_x,
    input  logic [2:0]       tile_y,
    input  logic [1:0]       sprite_id,
    output logic             plot,
    output tile_pkg::pixel_t pixel,
    output logic             done
);
    import tile_pkg::*;

    localparam tile_pos_t POS_LAST = tile_pos_t'(TILE_SIZE - 1);

    logic [3:0] tile_x_q;
    logic [2:0] tile_y_q;
    logic [1:0] sprite_q;
    logic       walking;
    tile_pos_t  col;
    tile_pos_t  row;
    logic       at_last;
    logic       last_q;
    logic [7:0] base_x;
    logic [6:0] base_y;
    colour_t    pat_colour;

    assign base_x  = 8'(tile_x_q * TILE_SIZE);
    assign base_y  = 7'(tile_y_q * TILE_SIZE);
    assign at_last = walking && (col == POS_LAST) && (row == POS_LAST);

    sprite_pattern u_pattern (
        .sprite_id (sprite_q),
        .px        (col),
        .py        (row),
        .colour    (pat_colour)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            walking <= 1'b0;
            col     <= '0;
            row     <= '0;
            plot    <= 1'b0;
            last_q  <= 1'b0;
            done    <= 1'b0;
        end else begin
            plot   <= walking && (pat_colour != TRANSPARENT_KEY);   // Skip see-through
            last_q <= at_last;
            done   <= last_q;
            if (start) begin
                walking <= 1'b1;
                col     <= '0;
                row     <= '0;
            end else if (walking) begin
                if (col == POS_LAST) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
                if (at_last) walking <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tile_x_q <= tile_x;
            tile_y_q <= tile_y;
            sprite_q <= sprite_id;
        end
        pixel <= '{x: base_x + {3'b000, col}, y: base_y + {2'b00, row}, colour: pat_colour};
    end

    plot_inside_tile: assert property (@(posedge clk) disable iff (!resetn)
        plot |-> (pixel.x >= base_x) && (pixel.x < base_x + 8'(TILE_SIZE))
              && (pixel.y >= base_y) && (pixel.y < base_y + 7'(TILE_SIZE)));

endmodule

`default_nettype wire

//--- screen_clearer.sv
`timescale 1ns/100ps
`default_nettype none

module screen_clearer (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  tile_pkg::colour_t fill_colour,
    output logic              plot,
    output tile_pkg::pixel_t  pixel,
    output logic              done
);
    import tile_pkg::*;

    localparam logic [7:0] COL_LAST = 8'(SCREEN_W - 1);
    localparam logic [6:0] ROW_LAST = 7'(SCREEN_H - 1);

    logic [7:0] col;
    logic [6:0] row;
    colour_t    colour_q;

    // Counters drive the stream directly
    assign pixel = '{x: col, y: row, colour: colour_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            plot <= 1'b0;
            col  <= '0;
            row  <= '0;
            done <= 1'b0;
        end else begin
            done <= plot && (col == COL_LAST) && (row == ROW_LAST);
            if (start) begin
                plot <= 1'b1;
                col  <= '0;
                row  <= '0;
            end else if (plot) begin
                if (col == COL_LAST) begin
                    col <= '0;
                    if (row == ROW_LAST) begin
                        row  <= '0;
                        plot <= 1'b0;           // Bottom right reached
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) colour_q <= fill_colour;
    end

endmodule

`default_nettype wire

//--- paint_control.sv
`timescale 1ns/100ps
`default_nettype none

module paint_control (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 cmd_valid,
    input  tile_pkg::paint_cmd_t cmd,
    input  logic                 erase_done,
    input  logic                 draw_done,
    input  logic                 clear_done,
    input  logic                 erase_plot,
    input  logic                 draw_plot,
    input  logic                 clear_plot,
    input  tile_pkg::pixel_t     erase_pixel,
    input  tile_pkg::pixel_t     draw_pixel,
    input  tile_pkg::pixel_t     clear_pixel,
    output logic                 erase_start,
    output logic                 draw_start,
    output logic                 clear_start,
    output logic [3:0]           tile_x,
    output logic [2:0]           tile_y,
    output logic [1:0]           sprite_id,
    output tile_pkg::colour_t    fill_colour,
    output logic                 busy,
    output logic                 done,
    output logic                 plot,
    output tile_pkg::pixel_t     pixel
);
    import tile_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ERASING,
        S_DRAWING,
        S_CLEARING,
        S_FINISHING
    } state_t;

    state_t state;
    logic   accept;

    assign busy   = (state == S_ERASING) || (state == S_DRAWING) || (state == S_CLEARING);
    assign done   = (state == S_FINISHING);
    assign accept = cmd_valid && !busy;   // Finishing also takes a new command

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= S_IDLE;
            erase_start <= 1'b0;
            draw_start  <= 1'b0;
            clear_start <= 1'b0;
        end else begin
            erase_start <= 1'b0;
            draw_start  <= 1'b0;
            clear_start <= 1'b0;
            case (state)
                S_ERASING:  if (erase_done) state <= S_FINISHING;
                S_DRAWING:  if (draw_done) state <= S_FINISHING;
                S_CLEARING: if (clear_done) state <= S_FINISHING;
                default: begin
                    state <= S_IDLE;
                    if (accept) begin
                        case (cmd.op)
                            OP_ERASE: begin
                                state       <= S_ERASING;
                                erase_start <= 1'b1;
                            end
                            OP_DRAW: begin
                                state      <= S_DRAWING;
                                draw_start <= 1'b1;
                            end
                            OP_CLEAR: begin
                                state       <= S_CLEARING;
                                clear_start <= 1'b1;
                            end
                            OP_NOP:   state <= S_FINISHING;   // done next cycle
                        endcase
                    end
                end
            endcase
        end
    end

    // Arguments for the engine, both union views kept
    always_ff @(posedge clk) begin
        if (accept) begin
            tile_x      <= cmd.arg.tile.tile_x;
            tile_y      <= cmd.arg.tile.tile_y;
            sprite_id   <= cmd.arg.tile.sprite_id;
            fill_colour <= cmd.arg.fill;
        end
    end

    // Route the running engine to the adapter
    always_comb begin
        plot  = 1'b0;
        pixel = erase_pixel;
        case (state)
            S_ERASING: begin
                plot  = erase_plot;
                pixel = erase_pixel;
            end
            S_DRAWING: begin
                plot  = draw_plot;
                pixel = draw_pixel;
            end
            S_CLEARING: begin
                plot  = clear_plot;
                pixel = clear_pixel;
            end
            default: plot = 1'b0;
        endcase
    end

    one_start_per_cycle: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0({erase_start, draw_start, clear_start}));

    // Engines only finish while the controller waits on them
    no_done_when_idle: assert property (@(posedge clk) disable iff (!resetn)
        (erase_done || draw_done || clear_done) |-> busy);

endmodule

`default_nettype wire

//--- tile_painter.sv
`timescale 1ns/100ps
`default_nettype none

module tile_painter #(
    parameter int SETTLE_CYCLES = 8
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 cmd_valid,
    input  tile_pkg::paint_cmd_t cmd,
    input  tile_pkg::colour_t    map_colour,
    output tile_pkg::map_addr_t  map_address,
    output logic                 busy,
    output logic                 done,
    output logic                 plot,
    output tile_pkg::pixel_t     pixel
);
    import tile_pkg::*;

    logic       erase_start, draw_start, clear_start;
    logic       erase_done, draw_done, clear_done;
    logic       erase_plot, draw_plot, clear_plot;
    pixel_t     erase_pixel, draw_pixel, clear_pixel;
    logic [3:0] tile_x;
    logic [2:0] tile_y;
    logic [1:0] sprite_id;
    colour_t    fill_colour;

    paint_control u_control (
        .clk         (clk),
        .resetn      (resetn),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .erase_done  (erase_done),
        .draw_done   (draw_done),
        .clear_done  (clear_done),
        .erase_plot  (erase_plot),
        .draw_plot   (draw_plot),
        .clear_plot  (clear_plot),
        .erase_pixel (erase_pixel),
        .draw_pixel  (draw_pixel),
        .clear_pixel (clear_pixel),
        .erase_start (erase_start),
        .draw_start  (draw_start),
        .clear_start (clear_start),
        .tile_x      (tile_x),
        .tile_y      (tile_y),
        .sprite_id   (sprite_id),
        .fill_colour (fill_colour),
        .busy        (busy),
        .done        (done),
        .plot        (plot),
        .pixel       (pixel)
    );

    square_eraser #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_eraser (
        .clk         (clk),
        .resetn      (resetn),
        .start       (erase_start),
        .tile_x      (tile_x),
        .tile_y      (tile_y),
        .map_colour  (map_colour),
        .map_address (map_address),
        .plot        (erase_plot),
        .pixel       (erase_pixel),
        .done        (erase_done)
    );

    sprite_drawer u_drawer (
        .clk       (clk),
        .resetn    (resetn),
        .start     (draw_start),
        .tile_x    (tile_x),
        .tile_y    (tile_y),
        .sprite_id (sprite_id),
        .plot      (draw_plot),
        .pixel     (draw_pixel),
        .done      (draw_done)
    );

    screen_clearer u_clearer (
        .clk         (clk),
        .resetn      (resetn),
        .start       (clear_start),
        .fill_colour (fill_colour),
        .plot        (clear_plot),
        .pixel       (clear_pixel),
        .done        (clear_done)
    );

endmodule

`default_nettype wire

//--- tile_painter_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tile_painter_checker (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 cmd_valid,
    input  tile_pkg::paint_cmd_t cmd,
    input  logic                 busy,
    input  logic                 done,
    input  logic                 plot,
    input  tile_pkg::pixel_t     pixel,
    input  tile_pkg::map_addr_t  map_address,
    output int                   error_count,
    output int                   done_count,
    output int                   plot_total
);
    import tile_pkg::*;

    localparam int TILE_PIXELS = TILE_SIZE * TILE_SIZE;

    paint_cmd_t cur_cmd;
    logic       active;
    int         plots;          // Plots seen for the running command
    int         cursor;         // Next raster index a sprite may plot at
    int         expected_plots;
    map_addr_t  addr_prev;      // Map address one cycle back

    // Background ROM contents seen through the map port
    function automatic colour_t background_colour(input int x, input int y);
        int addr;
        addr = y * SCREEN_W + x;
        return colour_t'((addr ^ (addr >> 6)) & 32'h1ff);
    endfunction

    function automatic colour_t sprite_colour(input int id, input int px, input int py);
        colour_t c;
        c = TRANSPARENT_KEY;
        case (id)
            0: c = SPRITE_SOLID_COLOUR;
            1: if (px == 0 || py == 0 || px == TILE_SIZE - 1 || py == TILE_SIZE - 1)
                c = SPRITE_BORDER_COLOUR;
            2: if (((px / 4) + (py / 4)) % 2 == 0)
                c = SPRITE_CHECK_COLOUR;
            default: if (px == py || px + py == TILE_SIZE - 1)
                c = SPRITE_DIAG_COLOUR;
        endcase
        return c;
    endfunction

    function automatic int opaque_count(input int id);
        int n;
        n = 0;
        for (int i = 0; i < TILE_PIXELS; i++) begin
            if (sprite_colour(id, i % TILE_SIZE, i / TILE_SIZE) != TRANSPARENT_KEY) n++;
        end
        return n;
    endfunction

    // First opaque raster index at or after from
    function automatic int next_opaque(input int id, input int from);
        int idx;
        idx = from;
        while (idx < TILE_PIXELS &&
               sprite_colour(id, idx % TILE_SIZE, idx / TILE_SIZE) == TRANSPARENT_KEY) begin
            idx++;
        end
        return idx;
    endfunction

    task automatic check_field(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("ERROR %s: got %h expected %h at %0t", name, got, expected, $time);
            error_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic check_pixel(input int ex, input int ey, input colour_t ec);
        check_field("pixel.x", int'(pixel.x), ex);
        check_field("pixel.y", int'(pixel.y), ey);
        check_field("pixel.colour", int'(pixel.colour), int'(ec));
    endtask

    initial begin
        error_count = 0;
        done_count  = 0;
        plot_total  = 0;
        active      = 1'b0;
        plots       = 0;
        cursor      = 0;
        addr_prev   = '0;
    end

    always @(posedge clk) begin
        int bx;
        int by;
        int sid;
        int ex;
        int ey;
        bx  = int'(cur_cmd.arg.tile.tile_x) * TILE_SIZE;
        by  = int'(cur_cmd.arg.tile.tile_y) * TILE_SIZE;
        sid = int'(cur_cmd.arg.tile.sprite_id);
        if (!resetn) begin
            active = 1'b0;
        end else begin
            if (plot) begin
                plot_total++;
                if (!active) begin
                    report_failure("plot seen with no command in progress");
                end else begin
                    case (cur_cmd.op)
                        OP_ERASE: begin
                            ex = bx + plots % TILE_SIZE;
                            ey = by + plots / TILE_SIZE;
                            if (plots >= TILE_PIXELS) begin
                                report_failure("erase produced more than one tile of plots");
                            end else begin
                                // Address goes out one cycle ahead of its plot
                                check_field("map_address", int'(addr_prev), ey * SCREEN_W + ex);
                                check_pixel(ex, ey, background_colour(ex, ey));
                            end
                        end
                        OP_DRAW: begin
                            cursor = next_opaque(sid, cursor);
                            if (cursor >= TILE_PIXELS) begin
                                report_failure("draw plotted past the last opaque pixel");
                            end else begin
                                check_pixel(bx + cursor % TILE_SIZE, by + cursor / TILE_SIZE,
                                    sprite_colour(sid, cursor % TILE_SIZE, cursor / TILE_SIZE));
                                cursor++;
                            end
                        end
                        OP_CLEAR: begin
                            if (plots >= SCREEN_PIXELS)
                                report_failure("clear produced more plots than the screen holds");
                            else
                                check_pixel(plots % SCREEN_W, plots / SCREEN_W,
                                            cur_cmd.arg.fill);
                        end
                        default: report_failure("plot seen during a NOP command");
                    endcase
                    plots++;
                end
            end

            if (done) begin
                done_count++;
                check_field("busy", int'(busy), 0);     // Falls together with done
                if (!active) begin
                    report_failure("done pulse with no command in progress");
                end else begin
                    check_field("plot count", plots, expected_plots);
                    active = 1'b0;
                end
            end else if (active) begin
                if (cur_cmd.op == OP_NOP) begin
                    report_failure("NOP command did not finish on the next cycle");
                    active = 1'b0;
                end else begin
                    check_field("busy", int'(busy), 1);
                end
            end

            // A strobe is taken only while busy is low
            if (cmd_valid && !busy) begin
                if (active) report_failure("command accepted while another was running");
                cur_cmd = cmd;
                active  = 1'b1;
                plots   = 0;
                cursor  = 0;
                case (cmd.op)
                    OP_ERASE: expected_plots = TILE_PIXELS;
                    OP_DRAW:  expected_plots = opaque_count(int'(cmd.arg.tile.sprite_id));
                    OP_CLEAR: expected_plots = SCREEN_PIXELS;
                    default:  expected_plots = 0;
                endcase
            end
        end
        addr_prev = map_address;
    end

endmodule

`default_nettype wire

//--- tile_painter_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tile_painter_tb;
    import tile_pkg::*;

    localparam int          SETTLE_CYCLES = 8;
    localparam int          NUM_CMDS      = 40;
    localparam int          RESET_CYCLES  = 10;
    localparam int          DRAIN_CYCLES  = 30;
    localparam int          SLACK_PER_CMD = 20;
    localparam int unsigned SEED          = 32'h112c_e580;

    logic       clk = 1'b0;
    logic       resetn;
    logic       cmd_valid;
    paint_cmd_t cmd;
    colour_t    map_colour;
    map_addr_t  map_address;
    logic       busy;
    logic       done;
    logic       plot;
    pixel_t     pixel;

    int         error_count;
    int         done_count;
    int         plot_total;
    int         tb_errors;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    paint_cmd_t cmd_list[NUM_CMDS];

    always #20 clk = ~clk;

    tile_painter #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) dut (
        .clk         (clk),
        .resetn      (resetn),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .map_colour  (map_colour),
        .map_address (map_address),
        .busy        (busy),
        .done        (done),
        .plot        (plot),
        .pixel       (pixel)
    );

    tile_painter_checker u_checker (
        .clk         (clk),
        .resetn      (resetn),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .busy        (busy),
        .done        (done),
        .plot        (plot),
        .pixel       (pixel),
        .map_address (map_address),
        .error_count (error_count),
        .done_count  (done_count),
        .plot_total  (plot_total)
    );

    // Background ROM with one cycle of read latency
    always @(posedge clk) begin
        map_colour <= colour_t'(map_address ^ (map_address >> 6));
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic paint_cmd_t random_command();
        paint_cmd_t c;
        c = '0;
        if ($urandom % 8 == 0) begin
            c.op       = OP_CLEAR;              // Rare since a clear takes 19200 cycles
            c.arg.fill = colour_t'($urandom);
        end else begin
            case ($urandom % 3)
                0:       c.op = OP_NOP;
                1:       c.op = OP_ERASE;
                default: c.op = OP_DRAW;
            endcase
            c.arg.tile.tile_x    = 4'($urandom % GRID_W);
            c.arg.tile.tile_y    = 3'($urandom % GRID_H);
            c.arg.tile.sprite_id = 2'($urandom % 4);
        end
        return c;
    endfunction

    function automatic int compute_limit();
        int total;
        total = RESET_CYCLES + DRAIN_CYCLES;
        foreach (cmd_list[i]) begin
            if (cmd_list[i].op == OP_CLEAR)
                total += SCREEN_PIXELS;
            else
                total += TILE_SIZE * TILE_SIZE + SETTLE_CYCLES;
            total += SLACK_PER_CMD;
        end
        return total;
    endfunction

    task automatic issue_command(input paint_cmd_t c);
        paint_cmd_t stray;
        @(posedge clk);
        while (busy) @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        cmd_valid <= 1'b0;
        // Extra strobe well inside the busy window
        if (c.op != OP_NOP && $urandom % 2 == 1) begin
            stray = random_command();
            repeat (3) @(posedge clk);
            cmd_valid <= 1'b1;
            cmd       <= stray;
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
    endtask

    initial begin
        resetn     = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        map_colour = '0;
        tb_errors  = 0;
        void'($urandom(SEED));
        foreach (cmd_list[i]) cmd_list[i] = random_command();
        cycle_limit = compute_limit();

        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        for (int i = 0; i < NUM_CMDS; i++) begin
            repeat ($urandom % 4) @(posedge clk);
            issue_command(cmd_list[i]);
        end
        @(posedge clk);
        while (busy) @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk);     // Catch stray plots or done

        if (done_count != NUM_CMDS) begin
            $display("ERROR done count: got %h expected %h", done_count, NUM_CMDS);
            tb_errors++;
        end
        $display("Checks done: %0d errors (checker %0d, testbench %0d), %0d done, %0d plots",
                 error_count + tb_errors, error_count, tb_errors, done_count, plot_total);
        if (error_count + tb_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tile_painter.f
tile_pkg.sv
sprite_pattern.sv
square_eraser.sv
sprite_drawer.sv
screen_clearer.sv
paint_control.sv
tile_painter.sv
tile_painter_checker.sv
tile_painter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the tile_painter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tile_painter_tb \
    --Mdir obj_dir \
    -f tile_painter.f

output=$(./obj_dir/Vtile_painter_tb)
echo "$output"

if echo "$output" | grep -qx ">>> PASS"; then
    exit 0
fi
exit 1
